/* claAdder.sv */
`timescale 1ns/1ps

module claAdder #(
    parameter int width = 16
) (
    input  logic [width-1:0] a,
    input  logic [width-1:0] b,
    input  logic             cin,
    output logic [width-1:0] sum,
    output logic             cout
);

    localparam int numGroups = width / 4;

    logic [width-1:0]     p;
    logic [width-1:0]     g;
    logic [width-1:0]     carry;
    logic [numGroups-1:0] groupProp;
    logic [numGroups-1:0] groupGen;
    logic [numGroups:0]   groupCarry;

    // per-bit propagate and generate
    assign p = a | b;
    assign g = a & b;

    assign groupCarry[0] = cin;

    genvar gi;
    for (gi = 0; gi < numGroups; gi++) begin : lookahead
        logic [3:0] gp;
        logic [3:0] gg;
        logic       c0;

        assign gp = p[4*gi +: 4];
        assign gg = g[4*gi +: 4];
        assign c0 = groupCarry[gi];

        // carries inside the group, all from the group carry-in
        assign carry[4*gi]     = c0;
        assign carry[4*gi + 1] = gg[0] | (gp[0] & c0);
        assign carry[4*gi + 2] = gg[1] | (gp[1] & gg[0]) | (gp[1] & gp[0] & c0);
        assign carry[4*gi + 3] = gg[2] | (gp[2] & gg[1]) | (gp[2] & gp[1] & gg[0])
                               | (gp[2] & gp[1] & gp[0] & c0);

        // group propagate and generate
        assign groupProp[gi] = &gp;
        assign groupGen[gi]  = gg[3] | (gp[3] & gg[2]) | (gp[3] & gp[2] & gg[1])
                             | (gp[3] & gp[2] & gp[1] & gg[0]);

        // group carries ripple from one group to the next
        assign groupCarry[gi + 1] = groupGen[gi] | (groupProp[gi] & c0);
    end

    assign sum  = a ^ b ^ carry;
    assign cout = groupCarry[numGroups];

endmodule

/* hackAlu.sv */
`timescale 1ns/1ps

module hackAlu (
    input  logic [hackPkg::wordWidth-1:0] x,
    input  logic [hackPkg::wordWidth-1:0] y,
    hackAluCtrlIf.alu                     ctrl,
    output logic [hackPkg::wordWidth-1:0] out,
    output logic                          zr,
    output logic                          ng
);

    import hackPkg::*;

    logic [wordWidth-1:0] xZero;
    logic [wordWidth-1:0] xIn;
    logic [wordWidth-1:0] yZero;
    logic [wordWidth-1:0] yIn;
    logic [wordWidth-1:0] andOut;
    logic [wordWidth-1:0] addOut;
    logic [wordWidth-1:0] fOut;

    // x stage
    assign xZero = ctrl.zx ? '0 : x;
    assign xIn   = ctrl.nx ? ~xZero : xZero;

    // y stage
    assign yZero = ctrl.zy ? '0 : y;
    assign yIn   = ctrl.ny ? ~yZero : yZero;

    assign andOut = xIn & yIn;

    // lookahead adder, carry out is not part of the Hack result
    claAdder #(
        .width(wordWidth)
    ) adder (
        .a   (xIn),
        .b   (yIn),
        .cin (1'b0),
        .sum (addOut),
        .cout()
    );

    assign fOut = ctrl.f ? addOut : andOut;

    // optional output negate
    assign out = ctrl.no ? ~fOut : fOut;

    // flags
    assign zr = (out == '0);
    assign ng = out[wordWidth-1];

endmodule

/* hackAluCtrlIf.sv */
`timescale 1ns/1ps

// the six Hack ALU control bits, from the decoder to the ALU
interface hackAluCtrlIf;

    // zero and negate x
    logic zx;
    logic nx;
    // zero and negate y
    logic zy;
    logic ny;
    // add when set, and otherwise
    logic f;
    // negate the result
    logic no;

    modport decoder (
        output zx, nx, zy, ny, f, no
    );

    modport alu (
        input zx, nx, zy, ny, f, no
    );

endinterface

/* hackCpu.sv */
`timescale 1ns/1ps

module hackCpu #(
    parameter int addrWidth = 15,
    parameter int ramDepth  = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    // instruction port
    input  logic [hackPkg::wordWidth-1:0] instr,
    input  logic                          instrValid,
    output logic                          instrReady,
    // retire port
    output logic                          retireValid,
    input  logic                          retireReady,
    output logic [hackPkg::pcWidth-1:0]   retirePc,
    output logic [hackPkg::pcWidth-1:0]   retireAddressM,
    output logic [hackPkg::wordWidth-1:0] retireOutM,
    output logic                          retireWriteM
);

    import hackPkg::*;

    logic                 advance;
    instrKindE            kind;
    logic [wordWidth-1:0] constant;
    logic                 selectM;
    logic                 destA;
    logic                 destD;
    logic                 destM;
    jumpCondE             jump;
    logic [wordWidth-1:0] aReg;
    logic [wordWidth-1:0] dReg;
    logic [wordWidth-1:0] inM;
    logic [wordWidth-1:0] aluY;
    logic [wordWidth-1:0] aluOut;
    logic                 zr;
    logic                 ng;
    logic [addrWidth-1:0] pc;
    retireT               retireRec;

    hackAluCtrlIf aluCtrl ();

    // one instruction in flight, the retire slot is the only buffer
    assign instrReady = !retireValid || retireReady;
    assign advance    = instrValid && instrReady;

    hackDecoder decoder (
        .instr   (instr),
        .kind    (kind),
        .constant(constant),
        .selectM (selectM),
        .destA   (destA),
        .destD   (destD),
        .destM   (destM),
        .jump    (jump),
        .ctrl    (aluCtrl.decoder)
    );

    // a-bit picks M over A
    assign aluY = selectM ? inM : aReg;

    hackAlu alu (
        .x   (dReg),
        .y   (aluY),
        .ctrl(aluCtrl.alu),
        .out (aluOut),
        .zr  (zr),
        .ng  (ng)
    );

    hackProgramCounter #(
        .addrWidth(addrWidth)
    ) programCounter (
        .clk    (clk),
        .reset  (reset),
        .advance(advance),
        .jump   (jump),
        .zr     (zr),
        .ng     (ng),
        .target (aReg[addrWidth-1:0]),
        .pc     (pc)
    );

    hackDataRam #(
        .addrWidth(addrWidth),
        .ramDepth (ramDepth)
    ) dataRam (
        .clk      (clk),
        .address  (aReg[addrWidth-1:0]),
        .writeData(aluOut),
        .write    (advance && destM),
        .readData (inM)
    );

    // A and D registers
    always_ff @(posedge clk) begin
        if (reset) begin
            aReg <= '0;
            dReg <= '0;
        end else if (advance) begin
            if (kind == instrA) begin
                aReg <= constant;
            end else if (destA) begin
                aReg <= aluOut;
            end
            if (destD) begin
                dReg <= aluOut;
            end
        end
    end

    // retire slot, held until the consumer takes it
    always_ff @(posedge clk) begin
        if (reset) begin
            retireValid <= 1'b0;
        end else if (advance) begin
            retireValid <= 1'b1;
        end else if (retireReady) begin
            retireValid <= 1'b0;
        end
    end

    // record uses pc and A from before this edge
    always_ff @(posedge clk) begin
        if (advance) begin
            retireRec.pc       <= pcWidth'(pc);
            retireRec.addressM <= aReg[pcWidth-1:0];
            retireRec.outM     <= aluOut;
            retireRec.writeM   <= destM;
        end
    end

    assign retirePc       = retireRec.pc;
    assign retireAddressM = retireRec.addressM;
    assign retireOutM     = retireRec.outM;
    assign retireWriteM   = retireRec.writeM;

endmodule

/* hackDataRam.sv */
`timescale 1ns/1ps

module hackDataRam #(
    parameter int addrWidth = 15,
    parameter int ramDepth  = 256
) (
    input  logic                          clk,
    input  logic [addrWidth-1:0]          address,
    input  logic [hackPkg::wordWidth-1:0] writeData,
    input  logic                          write,
    output logic [hackPkg::wordWidth-1:0] readData
);

    import hackPkg::*;

    localparam int indexWidth = $clog2(ramDepth);

    logic [wordWidth-1:0]  mem [ramDepth];
    logic [indexWidth-1:0] index;

    // addresses beyond the array fold back onto it
    assign index = indexWidth'(address % ramDepth);

    assign readData = mem[index];

    always_ff @(posedge clk) begin
        if (write) begin
            mem[index] <= writeData;
        end
    end

endmodule

/* hackDecoder.sv */
`timescale 1ns/1ps

module hackDecoder (
    input  logic [hackPkg::wordWidth-1:0] instr,
    output hackPkg::instrKindE            kind,
    output logic [hackPkg::wordWidth-1:0] constant,
    output logic                          selectM,
    output logic                          destA,
    output logic                          destD,
    output logic                          destM,
    output hackPkg::jumpCondE             jump,
    hackAluCtrlIf.decoder                 ctrl
);

    import hackPkg::*;

    logic isC;

    assign isC  = instr[wordWidth-1];
    assign kind = isC ? instrC : instrA;

    // A-instruction payload, zero-extended
    assign constant = {1'b0, instr[constWidth-1:0]};

    // comp field
    assign ctrl.zx = instr[11];
    assign ctrl.nx = instr[10];
    assign ctrl.zy = instr[9];
    assign ctrl.ny = instr[8];
    assign ctrl.f  = instr[7];
    assign ctrl.no = instr[6];

    // an A-instruction never reads M, writes nothing and never jumps
    assign selectM = isC & instr[12];
    assign destA   = isC & instr[5];
    assign destD   = isC & instr[4];
    assign destM   = isC & instr[3];
    assign jump    = isC ? jumpCondE'(instr[2:0]) : jmpNever;

endmodule

/* hackPkg.sv */
package hackPkg;

    // data path and instruction field widths
    localparam int wordWidth  = 16;
    localparam int constWidth = 15;
    localparam int pcWidth    = 15;

    // bit 15 of the instruction picks the kind
    typedef enum logic {
        instrA = 1'b0,
        instrC = 1'b1
    } instrKindE;

    // encoded as in the three jump bits of a C-instruction
    typedef enum logic [2:0] {
        jmpNever  = 3'b000,
        jmpGt     = 3'b001,
        jmpEq     = 3'b010,
        jmpGe     = 3'b011,
        jmpLt     = 3'b100,
        jmpNe     = 3'b101,
        jmpLe     = 3'b110,
        jmpAlways = 3'b111
    } jumpCondE;

    // one record per executed instruction
    typedef struct packed {
        // address of the instruction itself
        logic [pcWidth-1:0]   pc;
        // A register as it was before execution
        logic [pcWidth-1:0]   addressM;
        // alu result
        logic [wordWidth-1:0] outM;
        logic                 writeM;
    } retireT;

endpackage

/* hackProgramCounter.sv */
`timescale 1ns/1ps

module hackProgramCounter #(
    parameter int addrWidth = 15
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 advance,
    input  hackPkg::jumpCondE    jump,
    input  logic                 zr,
    input  logic                 ng,
    input  logic [addrWidth-1:0] target,
    output logic [addrWidth-1:0] pc
);

    import hackPkg::*;

    logic                 taken;
    logic [wordWidth-1:0] incSum;

    // jump decision from the alu flags
    always_comb begin
        case (jump)
            jmpNever:  taken = 1'b0;
            jmpGt:     taken = !zr && !ng;
            jmpEq:     taken = zr;
            jmpGe:     taken = !ng;
            jmpLt:     taken = ng;
            jmpNe:     taken = !zr;
            jmpLe:     taken = zr || ng;
            jmpAlways: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    // pc + 1 through the carry-in
    claAdder #(
        .width(wordWidth)
    ) incrementer (
        .a   (wordWidth'(pc)),
        .b   ('0),
        .cin (1'b1),
        .sum (incSum),
        .cout()
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (advance) begin
            pc <= taken ? target : incSum[addrWidth-1:0];
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# build the Hack CPU testbench with Verilator, run it and scan the log
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tbHackCpu -f sources.f -o simHackCpu \
    || { echo "build failed"; exit 1; }
./obj_dir/simHackCpu > sim.log 2>&1 || echo "simulator returned an error"
test -f sim.log && cat sim.log || { echo "no simulation log"; exit 1; }
grep -q "Errors found" sim.log && exit 1 || exit 0

/* sources.f */
hackPkg.sv
hackAluCtrlIf.sv
claAdder.sv
hackAlu.sv
hackDecoder.sv
hackProgramCounter.sv
hackDataRam.sv
hackCpu.sv
tbChecker.sv
tbHackCpu.sv

/* tbChecker.sv */
`timescale 1ns/1ps

module tbChecker #(
    parameter int ramDepth = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [hackPkg::wordWidth-1:0] instr,
    input  logic                          instrValid,
    input  logic                          instrReady,
    input  logic                          retireValid,
    input  logic                          retireReady,
    input  hackPkg::retireT               retireRec,
    output int                            errorCount,
    output int                            retiredCount
);

    import hackPkg::*;

    logic [wordWidth-1:0] refA;
    logic [wordWidth-1:0] refD;
    logic [pcWidth-1:0]   refPc;
    logic [wordWidth-1:0] refRam [ramDepth];
    retireT               expectQ [$];
    bit                   outCheckQ [$];
    retireT               want;
    retireT               heldRec;
    logic                 held;
    bit                   checkOut;

    // applies one instruction to the model state and returns the expected record
    function automatic retireT referenceStep(input logic [wordWidth-1:0] ins);
        retireT               rec;
        logic [wordWidth-1:0] d;
        logic [wordWidth-1:0] y;
        logic [wordWidth-1:0] res;
        logic                 taken;
        rec = {refPc, refA[pcWidth-1:0], {wordWidth{1'b0}}, 1'b0};
        if (!ins[15]) begin
            refA  = {1'b0, ins[14:0]};
            refPc = refPc + 1'b1;
            return rec;
        end
        d = refD;
        y = ins[12] ? refRam[refA % ramDepth] : refA;
        // Hack comp table with y for A or M
        case (ins[11:6])
            6'b101010: res = '0;
            6'b111111: res = 16'd1;
            6'b111010: res = '1;
            6'b001100: res = d;
            6'b110000: res = y;
            6'b001101: res = ~d;
            6'b110001: res = ~y;
            6'b001111: res = -d;
            6'b110011: res = -y;
            6'b011111: res = d + 16'd1;
            6'b110111: res = y + 16'd1;
            6'b001110: res = d - 16'd1;
            6'b110010: res = y - 16'd1;
            6'b000010: res = d + y;
            6'b010011: res = d - y;
            6'b000111: res = y - d;
            6'b000000: res = d & y;
            6'b010101: res = d | y;
            default:   res = 'x;
        endcase
        // j1 j2 j3 select negative, zero and positive results
        taken = (ins[2] && res[15]) || (ins[1] && res == '0)
              || (ins[0] && !res[15] && res != '0);
        refPc = taken ? refA[pcWidth-1:0] : refPc + 1'b1;
        if (ins[3]) begin
            refRam[refA % ramDepth] = res;
        end
        if (ins[4]) begin
            refD = res;
        end
        if (ins[5]) begin
            refA = res;
        end
        rec.outM   = res;
        rec.writeM = ins[3];
        return rec;
    endfunction

    task automatic compareField(input string name, input logic [wordWidth-1:0] got,
                                input logic [wordWidth-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            errorCount++;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            refA         = '0;
            refD         = '0;
            refPc        = '0;
            held         = 1'b0;
            errorCount   = 0;
            retiredCount = 0;
            expectQ.delete();
            outCheckQ.delete();
        end else begin
            // a new instruction enters only when no record waits or it leaves now
            compareField("instrReady", wordWidth'(instrReady),
                         wordWidth'(expectQ.size() == 0 || retireReady));
            // a record not yet taken must stay valid and unchanged
            if (held && !retireValid) begin
                $display("ERROR at %0t: retireValid dropped before the record was taken", $time);
                errorCount++;
            end else if (held && retireRec !== heldRec) begin
                $display("ERROR at %0t: retire record changed while it was held", $time);
                errorCount++;
            end
            if (retireValid && expectQ.size() == 0) begin
                $display("ERROR at %0t: retire record with no accepted instruction behind it",
                         $time);
                errorCount++;
            end else if (retireValid && retireReady) begin
                want     = expectQ.pop_front();
                checkOut = outCheckQ.pop_front();
                compareField("retirePc", wordWidth'(retireRec.pc), wordWidth'(want.pc));
                compareField("retireAddressM", wordWidth'(retireRec.addressM),
                             wordWidth'(want.addressM));
                // outM only means something for C-instructions
                if (checkOut) begin
                    compareField("retireOutM", retireRec.outM, want.outM);
                end
                compareField("retireWriteM", wordWidth'(retireRec.writeM),
                             wordWidth'(want.writeM));
                retiredCount++;
            end
            held    = retireValid && !retireReady;
            heldRec = retireRec;
            if (instrValid && instrReady) begin
                outCheckQ.push_back(instr[wordWidth-1]);
                expectQ.push_back(referenceStep(instr));
            end
        end
    end

endmodule

/* tbHackCpu.sv */
`timescale 1ns/1ps

module tbHackCpu;

    import hackPkg::*;

    localparam int addrWidth      = 15;
    localparam int ramDepth       = 256;
    localparam int cyclesPerInstr = 40;
    localparam int timeoutBase    = 200;

    // comp field of the 18 Hack computations
    localparam logic [5:0] compCodes [18] = '{
        6'b101010, 6'b111111, 6'b111010, 6'b001100, 6'b110000, 6'b001101,
        6'b110001, 6'b001111, 6'b110011, 6'b011111, 6'b110111, 6'b001110,
        6'b110010, 6'b000010, 6'b010011, 6'b000111, 6'b000000, 6'b010101
    };
    localparam logic [5:0] compD    = 6'b001100;
    localparam logic [5:0] compA    = 6'b110000;
    localparam logic [5:0] compNotD = 6'b001101;
    // destination bits in A D M order
    localparam logic [2:0] toNone = 3'b000;
    localparam logic [2:0] toM    = 3'b001;
    localparam logic [2:0] toD    = 3'b010;

    logic                 clk = 1'b0;
    logic                 reset;
    logic [wordWidth-1:0] instr;
    logic                 instrValid;
    logic                 instrReady;
    logic                 retireValid;
    logic                 retireReady;
    logic [pcWidth-1:0]   retirePc;
    logic [pcWidth-1:0]   retireAddressM;
    logic [wordWidth-1:0] retireOutM;
    logic                 retireWriteM;
    int                   errorCount;
    int                   retiredCount;
    integer               seed = 32'hd81e6c93;
    logic [wordWidth-1:0] prog [$];
    int                   plannedCount = 0;
    int                   cycleCount = 0;
    int                   testCount = 0;
    bit                   randomReady = 1'b0;
    int                   readyDraw;

    always #10 clk = ~clk;

    hackCpu #(
        .addrWidth(addrWidth),
        .ramDepth (ramDepth)
    ) dut (
        .clk           (clk),
        .reset         (reset),
        .instr         (instr),
        .instrValid    (instrValid),
        .instrReady    (instrReady),
        .retireValid   (retireValid),
        .retireReady   (retireReady),
        .retirePc      (retirePc),
        .retireAddressM(retireAddressM),
        .retireOutM    (retireOutM),
        .retireWriteM  (retireWriteM)
    );

    tbChecker #(
        .ramDepth(ramDepth)
    ) scoreboard (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .instrValid  (instrValid),
        .instrReady  (instrReady),
        .retireValid (retireValid),
        .retireReady (retireReady),
        .retireRec   ({retirePc, retireAddressM, retireOutM, retireWriteM}),
        .errorCount  (errorCount),
        .retiredCount(retiredCount)
    );

    // retire consumer, random only during the back-pressure test
    always @(posedge clk) begin
        #1;
        if (randomReady) begin
            readyDraw   = $random(seed);
            retireReady = readyDraw[0];
        end else begin
            retireReady = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cyclesPerInstr * plannedCount + timeoutBase) begin
            $display("TIMEOUT after %0d cycles, %0d of %0d instructions retired",
                     cycleCount, retiredCount, plannedCount);
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [wordWidth-1:0] randomWord();
        int r;
        r = $random(seed);
        return r[wordWidth-1:0];
    endfunction

    function automatic void emitA(input logic [14:0] value);
        prog.push_back({1'b0, value});
    endfunction

    function automatic void emitC(input logic aBit, input logic [5:0] comp,
                                  input logic [2:0] dest, input logic [2:0] jmp);
        prog.push_back({3'b111, aBit, comp, dest, jmp});
    endfunction

    // constants are 15 bits, so negative values go in inverted
    function automatic void emitLoadD(input logic [wordWidth-1:0] value);
        emitA(value[15] ? ~value[14:0] : value[14:0]);
        emitC(1'b0, compA, toD, 3'b000);
        if (value[15]) begin
            emitC(1'b0, compNotD, toD, 3'b000);
        end
    endfunction

    task automatic sendInstr(input logic [wordWidth-1:0] ins);
        logic ready;
        instr      = ins;
        instrValid = 1'b1;
        ready      = 1'b0;
        while (!ready) begin
            // settled mid-cycle, the transfer happens on the next edge
            @(negedge clk);
            ready = instrReady;
            @(posedge clk);
        end
        #1;
    endtask

    task automatic runProgram(input string name);
        int errorsBefore;
        errorsBefore = errorCount;
        plannedCount += prog.size();
        foreach (prog[i]) begin
            sendInstr(prog[i]);
        end
        instrValid = 1'b0;
        while (retiredCount < plannedCount) begin
            @(negedge clk);
        end
        testCount++;
        $display("test %0d (%s): %0d instructions, %0d errors", testCount, name,
                 prog.size(), errorCount - errorsBefore);
        prog.delete();
        @(posedge clk);
        #1;
    endtask

    initial begin
        logic [wordWidth-1:0] value;
        logic [14:0]          addrs [8];
        reset       = 1'b1;
        instr       = '0;
        instrValid  = 1'b0;
        retireReady = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        // idle, nothing may retire yet
        repeat (3) @(posedge clk);
        #1;

        emitA(15'd5);
        emitC(1'b0, compD, toNone, 3'b000);
        runProgram("first retire after reset");

        for (int k = 0; k < 8; k++) begin
            value = randomWord();
            emitA(value[14:0]);
            emitC(1'b0, compCodes[0], toNone, 3'b000);
        end
        runProgram("A-instruction constants");

        for (int m = 0; m < 2; m++) begin
            for (int c = 0; c < 18; c++) begin
                value = randomWord();
                emitLoadD(randomWord());
                emitA(value[14:0]);
                emitC(1'b0, compD, toM, 3'b000);
                emitLoadD(randomWord());
                emitA(value[14:0]);
                emitC(m[0], compCodes[c], toNone, 3'b000);
            end
        end
        runProgram("comp codes with A and M");

        for (int k = 0; k < 8; k++) begin
            value    = randomWord();
            addrs[k] = value[14:0];
            emitLoadD(randomWord());
            emitA(addrs[k]);
            emitC(1'b0, compD, toM, 3'b000);
        end
        for (int k = 0; k < 8; k++) begin
            emitA(addrs[k]);
            emitC(1'b1, compA, toD, 3'b000);
        end
        runProgram("memory write and read back");

        for (int j = 0; j < 8; j++) begin
            for (int s = 0; s < 3; s++) begin
                value = randomWord();
                // negative, zero and positive D
                value = (s == 0) ? (value | 16'h8000) :
                        (s == 1) ? 16'h0000 : ((value & 16'h7fff) | 16'h0001);
                emitLoadD(value);
                value = randomWord();
                emitA(value[14:0]);
                emitC(1'b0, compD, toNone, j[2:0]);
            end
        end
        emitC(1'b0, compD, toNone, 3'b000);
        runProgram("jump conditions");

        for (int k = 0; k < 80; k++) begin
            value = randomWord();
            if (value[15]) begin
                emitA(value[14:0]);
            end else begin
                emitC(1'b0, compCodes[value[4:0] % 18], value[7:5], value[10:8]);
            end
        end
        @(negedge clk);
        randomReady = 1'b1;
        @(posedge clk);
        #1;
        runProgram("random back-pressure");
        @(negedge clk);
        randomReady = 1'b0;

        $display("tests: %0d, instructions: %0d, retired: %0d, errors: %0d",
                 testCount, plannedCount, retiredCount, errorCount);
        if (errorCount == 0 && retiredCount == plannedCount) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
